/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Major opcodes handled by the execute unit
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_load      = 7'b0000011;
  localparam logic [6:0] opc_store     = 7'b0100011;

  // funct3 of the integer register and immediate groups
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct7 bit that turns add into sub and srl into sra
  localparam int f7_alt_bit = 5;

  // One instruction word, seen as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fields;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fields;
  } rv_instr_u;

endpackage

/* source/alu_pkg.sv */
package alu_pkg;

  // Data path width, fixed by RV64
  localparam int xlen = 64;

  localparam int alu_op_w = 4;

  // ALU operation codes
  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

  // Operand A source
  localparam logic src_a_rs1 = 1'b0;
  localparam logic src_a_pc  = 1'b1;

endpackage

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  rv_isa_pkg::rv_instr_u        instr,
  input  logic [alu_pkg::xlen-1:0]     pc,
  input  logic [alu_pkg::xlen-1:0]     rs1_data,
  input  logic [alu_pkg::xlen-1:0]     rs2_data,
  output logic                         d_valid,
  output logic [alu_pkg::alu_op_w-1:0] d_op,
  output logic                         d_word,
  output logic [alu_pkg::xlen-1:0]     d_a,
  output logic [alu_pkg::xlen-1:0]     d_b,
  output logic [4:0]                   d_rd,
  output logic                         d_illegal
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       alt;
  logic       f7_rest;
  logic       f7_upper;

  logic [alu_pkg::xlen-1:0] imm_i;
  logic [alu_pkg::xlen-1:0] imm_s;
  logic [alu_pkg::xlen-1:0] imm_u;

  logic [alu_pkg::alu_op_w-1:0] op_c;
  logic                         word_c;
  logic                         illegal_c;
  logic                         a_sel_c;
  logic                         a_zero_c;
  logic                         b_imm_c;
  logic [alu_pkg::xlen-1:0]     imm_c;
  logic [alu_pkg::xlen-1:0]     a_c;
  logic [alu_pkg::xlen-1:0]     b_c;

  // Shared funct3 mapping of the register and immediate groups
  function automatic logic [alu_pkg::alu_op_w-1:0] reg_op(input logic [2:0] fn3,
                                                          input logic       use_alt);
    case (fn3)
      rv_isa_pkg::f3_add:  reg_op = use_alt ? alu_pkg::alu_sub : alu_pkg::alu_add;
      rv_isa_pkg::f3_sll:  reg_op = alu_pkg::alu_sll;
      rv_isa_pkg::f3_slt:  reg_op = alu_pkg::alu_slt;
      rv_isa_pkg::f3_sltu: reg_op = alu_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:  reg_op = alu_pkg::alu_xor;
      rv_isa_pkg::f3_sr:   reg_op = use_alt ? alu_pkg::alu_sra : alu_pkg::alu_srl;
      rv_isa_pkg::f3_or:   reg_op = alu_pkg::alu_or;
      default:             reg_op = alu_pkg::alu_and;
    endcase
  endfunction

  assign opcode = instr.r_fields.opcode;
  assign f3     = instr.r_fields.funct3;
  assign f7     = instr.r_fields.funct7;
  assign alt    = f7[rv_isa_pkg::f7_alt_bit];

  // Any funct7 bit set apart from the alternate bit
  assign f7_rest  = |{f7[6:rv_isa_pkg::f7_alt_bit+1], f7[rv_isa_pkg::f7_alt_bit-1:0]};
  // Bit 0 is shamt[5] in 64-bit immediate shifts
  assign f7_upper = |{f7[6:rv_isa_pkg::f7_alt_bit+1], f7[rv_isa_pkg::f7_alt_bit-1:1]};

  assign imm_i = {{(alu_pkg::xlen-12){instr.i_fields.imm12[11]}}, instr.i_fields.imm12};
  assign imm_s = {{(alu_pkg::xlen-12){f7[6]}}, f7, instr.r_fields.rd};
  assign imm_u = {{(alu_pkg::xlen-32){instr.i_fields.imm12[11]}}, instr.i_fields.imm12,
                  instr.i_fields.rs1, instr.i_fields.funct3, 12'b0};

  always_comb begin
    op_c      = alu_pkg::alu_add;
    word_c    = 1'b0;
    illegal_c = 1'b0;
    a_sel_c   = alu_pkg::src_a_rs1;
    a_zero_c  = 1'b0;
    b_imm_c   = 1'b0;
    imm_c     = imm_i;
    case (opcode)
      rv_isa_pkg::opc_op, rv_isa_pkg::opc_op_32: begin
        word_c    = (opcode == rv_isa_pkg::opc_op_32);
        op_c      = reg_op(f3, alt);
        illegal_c = f7_rest
                    || (alt && f3 != rv_isa_pkg::f3_add && f3 != rv_isa_pkg::f3_sr)
                    || (word_c && !(f3 inside {rv_isa_pkg::f3_add, rv_isa_pkg::f3_sll,
                                               rv_isa_pkg::f3_sr}));
      end
      rv_isa_pkg::opc_op_imm, rv_isa_pkg::opc_op_imm_32: begin
        word_c  = (opcode == rv_isa_pkg::opc_op_imm_32);
        b_imm_c = 1'b1;
        // Immediates have no sub form, so alt only matters for right shifts
        op_c    = reg_op(f3, alt && (f3 == rv_isa_pkg::f3_sr));
        if (f3 == rv_isa_pkg::f3_sll) begin
          illegal_c = alt || (word_c ? f7_rest : f7_upper);
        end else if (f3 == rv_isa_pkg::f3_sr) begin
          illegal_c = word_c ? f7_rest : f7_upper;
        end else begin
          illegal_c = word_c && (f3 != rv_isa_pkg::f3_add);
        end
      end
      rv_isa_pkg::opc_lui: begin
        op_c     = alu_pkg::alu_pass_b;
        a_zero_c = 1'b1;
        b_imm_c  = 1'b1;
        imm_c    = imm_u;
      end
      rv_isa_pkg::opc_auipc: begin
        a_sel_c = alu_pkg::src_a_pc;
        b_imm_c = 1'b1;
        imm_c   = imm_u;
      end
      rv_isa_pkg::opc_load: begin
        b_imm_c   = 1'b1;
        // No unsigned doubleword load
        illegal_c = (f3 == 3'b111);
      end
      rv_isa_pkg::opc_store: begin
        b_imm_c   = 1'b1;
        imm_c     = imm_s;
        illegal_c = f3[2];
      end
      default: illegal_c = 1'b1;
    endcase
  end

  assign a_c = a_zero_c ? '0 : ((a_sel_c == alu_pkg::src_a_pc) ? pc : rs1_data);
  assign b_c = b_imm_c ? imm_c : rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      d_op      <= op_c;
      d_word    <= word_c;
      d_a       <= a_c;
      d_b       <= b_c;
      d_rd      <= instr.i_fields.rd;
      d_illegal <= illegal_c;
    end
  end

  // A valid stage-one entry always carries a decoded operation
  a_op_known: assert property (@(posedge clk) disable iff (rst)
    d_valid |-> !$isunknown(d_op));

endmodule

/* source/alu_core.sv */
`timescale 1ns/1ps

module alu_core (
  input  logic [alu_pkg::alu_op_w-1:0] op,
  input  logic                         word,
  input  logic [alu_pkg::xlen-1:0]     a,
  input  logic [alu_pkg::xlen-1:0]     b,
  output logic [alu_pkg::xlen-1:0]     alu_out
);

  logic [5:0]               shamt;
  logic [31:0]              a_lo;
  logic                     lt_s;
  logic                     lt_u;

  logic [alu_pkg::xlen-1:0] sll_d;
  logic [alu_pkg::xlen-1:0] srl_d;
  logic [alu_pkg::xlen-1:0] sra_d;
  logic [31:0]              sll_w;
  logic [31:0]              srl_w;
  logic [31:0]              sra_w;

  logic [alu_pkg::xlen-1:0] sll_r;
  logic [alu_pkg::xlen-1:0] srl_r;
  logic [alu_pkg::xlen-1:0] sra_r;

  assign shamt = b[5:0];
  assign a_lo  = a[31:0];

  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  assign sll_d = a << shamt;
  assign srl_d = a >> shamt;
  assign sra_d = $signed(a) >>> shamt;

  // Word forms act on the low half, sraw takes its sign from bit 31
  assign sll_w = a_lo << shamt[4:0];
  assign srl_w = a_lo >> shamt[4:0];
  assign sra_w = $signed(a_lo) >>> shamt[4:0];

  // Upper half of word results is rebuilt in the formatter
  assign sll_r = word ? {32'b0, sll_w} : sll_d;
  assign srl_r = word ? {32'b0, srl_w} : srl_d;
  assign sra_r = word ? {32'b0, sra_w} : sra_d;

  always_comb begin
    case (op)
      alu_pkg::alu_add:    alu_out = a + b;
      alu_pkg::alu_sub:    alu_out = a - b;
      alu_pkg::alu_sll:    alu_out = sll_r;
      alu_pkg::alu_slt:    alu_out = {{(alu_pkg::xlen-1){1'b0}}, lt_s};
      alu_pkg::alu_sltu:   alu_out = {{(alu_pkg::xlen-1){1'b0}}, lt_u};
      alu_pkg::alu_xor:    alu_out = a ^ b;
      alu_pkg::alu_srl:    alu_out = srl_r;
      alu_pkg::alu_sra:    alu_out = sra_r;
      alu_pkg::alu_or:     alu_out = a | b;
      alu_pkg::alu_and:    alu_out = a & b;
      alu_pkg::alu_pass_b: alu_out = b;
      default:             alu_out = '0;
    endcase
  end

endmodule

/* source/result_formatter.sv */
`timescale 1ns/1ps

module result_formatter (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     d_valid,
  input  logic                     d_word,
  input  logic [4:0]               d_rd,
  input  logic                     d_illegal,
  input  logic [alu_pkg::xlen-1:0] alu_out,
  output logic                     result_valid,
  output logic [alu_pkg::xlen-1:0] result,
  output logic [4:0]               rd,
  output logic                     illegal
);

  logic [alu_pkg::xlen-1:0] ext_c;
  logic [alu_pkg::xlen-1:0] fmt_c;

  // Word results are sign-extended from bit 31
  assign ext_c = d_word ? {{(alu_pkg::xlen-32){alu_out[31]}}, alu_out[31:0]} : alu_out;
  assign fmt_c = d_illegal ? '0 : ext_c;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      result       <= '0;
      rd           <= '0;
      illegal      <= 1'b0;
    end else begin
      result_valid <= d_valid;
      if (d_valid) begin
        result  <= fmt_c;
        rd      <= d_rd;
        illegal <= d_illegal;
      end
    end
  end

  // A flagged result never carries unknown bits
  a_result_known: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> !$isunknown({result, rd, illegal}));

endmodule

/* source/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic [31:0]              instr,
  input  logic [alu_pkg::xlen-1:0] pc,
  input  logic [alu_pkg::xlen-1:0] rs1_data,
  input  logic [alu_pkg::xlen-1:0] rs2_data,
  output logic                     result_valid,
  output logic [alu_pkg::xlen-1:0] result,
  output logic [4:0]               rd,
  output logic                     illegal
);

  logic                         d_valid;
  logic [alu_pkg::alu_op_w-1:0] d_op;
  logic                         d_word;
  logic [alu_pkg::xlen-1:0]     d_a;
  logic [alu_pkg::xlen-1:0]     d_b;
  logic [4:0]                   d_rd;
  logic                         d_illegal;
  logic [alu_pkg::xlen-1:0]     alu_out;

  // Stage one
  instr_decoder u_decoder (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .d_valid   (d_valid),
    .d_op      (d_op),
    .d_word    (d_word),
    .d_a       (d_a),
    .d_b       (d_b),
    .d_rd      (d_rd),
    .d_illegal (d_illegal)
  );

  alu_core u_alu (
    .op      (d_op),
    .word    (d_word),
    .a       (d_a),
    .b       (d_b),
    .alu_out (alu_out)
  );

  // Stage two
  result_formatter u_formatter (
    .clk          (clk),
    .rst          (rst),
    .d_valid      (d_valid),
    .d_word       (d_word),
    .d_rd         (d_rd),
    .d_illegal    (d_illegal),
    .alu_out      (alu_out),
    .result_valid (result_valid),
    .result       (result),
    .rd           (rd),
    .illegal      (illegal)
  );

endmodule

/* tests/exec_vectors.svh */
// One row per call with instr, rs1_data, rs2_data and pc, then the expected result, rd and illegal
// add_gap leaves in_valid low for one cycle

// Register-register group
add_row(32'h002081b3, 64'h7fffffff, 64'h1, 64'h0, 64'h80000000, 3, 0);
add_row(32'h40208233, 64'h0, 64'h1, 64'h0, 64'hffffffffffffffff, 4, 0);
add_row(32'h002092b3, 64'h3, 64'h7f, 64'h0, 64'h8000000000000000, 5, 0);
add_row(32'h0020a333, 64'hffffffffffffffff, 64'h1, 64'h0, 64'h1, 6, 0);
add_row(32'h0020b3b3, 64'hffffffffffffffff, 64'h1, 64'h0, 64'h0, 7, 0);
add_row(32'h0020b3b3, 64'h1, 64'hffffffffffffffff, 64'h0, 64'h1, 7, 0);
add_row(32'h0020c433, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'h0, 64'h0ff00ff00ff00ff0, 8, 0);
add_row(32'h0020d4b3, 64'h8000000000000000, 64'h4, 64'h0, 64'h0800000000000000, 9, 0);
add_row(32'h4020d533, 64'h8000000000000000, 64'h4, 64'h0, 64'hf800000000000000, 10, 0);
add_row(32'h0020e5b3, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'h0, 64'hfff0fff0fff0fff0, 11, 0);
add_row(32'h0020f633, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'h0, 64'hf000f000f000f000, 12, 0);
add_gap();

// Immediate group, rs2 carries junk that must be ignored
add_row(32'hfff08693, 64'h10, 64'h1234, 64'h0, 64'hf, 13, 0);
add_row(32'h02809713, 64'h1, 64'h1234, 64'h0, 64'h0000010000000000, 14, 0);
add_row(32'h4240d793, 64'h8000000000000000, 64'h1234, 64'h0, 64'hfffffffff8000000, 15, 0);
add_row(32'hfff0a813, 64'hfffffffffffffffe, 64'h1234, 64'h0, 64'h1, 16, 0);
add_row(32'h0010b893, 64'hfffffffffffffffe, 64'h1234, 64'h0, 64'h0, 17, 0);
add_row(32'hfff0b893, 64'hfffffffffffffffe, 64'h1234, 64'h0, 64'h1, 17, 0);
add_row(32'h7ff0c913, 64'hfffffffffffff000, 64'h1234, 64'h0, 64'hfffffffffffff7ff, 18, 0);
add_row(32'hf000f993, 64'h123456789abcdef0, 64'h1234, 64'h0, 64'h123456789abcde00, 19, 0);

// Load and store address adds, a store reports imm[4:0] as rd
add_row(32'hff80ba03, 64'h1000, 64'h0, 64'h0, 64'hff8, 20, 0);
add_row(32'h0220b423, 64'h2000, 64'h77, 64'h0, 64'h2028, 8, 0);
add_row(32'hfe20b823, 64'h2000, 64'h77, 64'h0, 64'h1ff0, 16, 0);

// Word forms
add_row(32'h00208abb, 64'h7fffffff, 64'h1, 64'h0, 64'hffffffff80000000, 21, 0);
add_row(32'h40208b3b, 64'h100000000, 64'h1, 64'h0, 64'hffffffffffffffff, 22, 0);
add_row(32'h00209bbb, 64'h1, 64'h3f, 64'h0, 64'hffffffff80000000, 23, 0);
add_row(32'h0020dc3b, 64'hffffffff80000000, 64'h4, 64'h0, 64'h08000000, 24, 0);
add_row(32'h4020dcbb, 64'h80000000, 64'h4, 64'h0, 64'hfffffffff8000000, 25, 0);
add_row(32'hfff08d1b, 64'h1234567880000000, 64'h0, 64'h0, 64'h7fffffff, 26, 0);
add_row(32'h00409d9b, 64'h08000001, 64'h0, 64'h0, 64'hffffffff80000010, 27, 0);
add_row(32'h4080de1b, 64'h80000000, 64'h0, 64'h0, 64'hffffffffff800000, 28, 0);

// Upper immediates
add_row(32'h80000eb7, 64'h5555, 64'h0, 64'h0, 64'hffffffff80000000, 29, 0);
add_row(32'h12345f37, 64'h5555, 64'h0, 64'h0, 64'h12345000, 30, 0);
add_row(32'hffffff97, 64'h0, 64'h0, 64'h8000000000001000, 64'h8000000000000000, 31, 0);
add_row(32'h00001097, 64'h0, 64'h0, 64'h1000, 64'h2000, 1, 0);

// Illegal encodings
add_row(32'h022081b3, 64'h5, 64'h7, 64'h0, 64'h0, 3, 1);
add_row(32'h40209233, 64'h5, 64'h7, 64'h0, 64'h0, 4, 1);
add_row(32'h0200929b, 64'h5, 64'h7, 64'h0, 64'h0, 5, 1);
add_row(32'h0000036f, 64'h5, 64'h7, 64'h0, 64'h0, 6, 1);
add_row(32'h0020a3bb, 64'h5, 64'h7, 64'h0, 64'h0, 7, 1);

/* tests/exec_unit_tb.sv */
`timescale 1ns/1ps

module exec_unit_tb;

  localparam int result_timeout = 20;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic [31:0] instr;
  logic [63:0] pc;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  logic        result_valid;
  logic [63:0] result;
  logic [4:0]  rd;
  logic        illegal;

  // Vector table, filled from exec_vectors.svh
  logic        row_valid[$];
  logic [31:0] row_instr[$];
  logic [63:0] row_rs1[$];
  logic [63:0] row_rs2[$];
  logic [63:0] row_pc[$];
  logic [63:0] row_result[$];
  logic [4:0]  row_rd[$];
  logic        row_illegal[$];

  int cycle = 0;
  int drive_cycle[$];
  // Rows that expect a result, in issue order
  int result_rows[$];

  exec_unit i_dut (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .instr        (instr),
    .pc           (pc),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result_valid (result_valid),
    .result       (result),
    .rd           (rd),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic add_row(input logic [31:0] word, input logic [63:0] a, input logic [63:0] b,
                         input logic [63:0] p, input logic [63:0] res, input logic [4:0] r,
                         input logic ill);
    result_rows.push_back(row_instr.size());
    row_valid.push_back(1'b1);
    row_instr.push_back(word);
    row_rs1.push_back(a);
    row_rs2.push_back(b);
    row_pc.push_back(p);
    row_result.push_back(res);
    row_rd.push_back(r);
    row_illegal.push_back(ill);
  endtask

  task automatic add_gap();
    row_valid.push_back(1'b0);
    row_instr.push_back('0);
    row_rs1.push_back('0);
    row_rs2.push_back('0);
    row_pc.push_back('0);
    row_result.push_back('0);
    row_rd.push_back('0);
    row_illegal.push_back(1'b0);
  endtask

  task automatic load_table();
    `include "exec_vectors.svh"
  endtask

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // One row per cycle, driven just after the rising edge
  task automatic drive_rows();
    for (int i = 0; i < row_instr.size(); i++) begin
      @(posedge clk);
      #2;
      in_valid = row_valid[i];
      instr    = row_instr[i];
      rs1_data = row_rs1[i];
      rs2_data = row_rs2[i];
      pc       = row_pc[i];
      drive_cycle.push_back(cycle);
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  // Outputs are sampled on the falling edge, away from the drive time
  task automatic watch_results();
    int row;
    int waited;
    for (int n = 0; n < result_rows.size(); n++) begin
      row = result_rows[n];
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (result_valid !== 1'b1 && waited < result_timeout);
      if (result_valid !== 1'b1) begin
        $display("Timeout: no result for table row %0d within %0d cycles", row, result_timeout);
        $display("Test failed");
        $fatal(1, "Result missing");
      end
      check_value($sformatf("row %0d latency", row), cycle - drive_cycle[row], 2);
      check_value($sformatf("row %0d result", row), result, row_result[row]);
      check_value($sformatf("row %0d rd", row), rd, row_rd[row]);
      check_value($sformatf("row %0d illegal", row), illegal, row_illegal[row]);
    end
  endtask

  task automatic check_idle();
    repeat (5) begin
      @(negedge clk);
      check_value("result_valid after last row", result_valid, 0);
    end
  endtask

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    instr    = '0;
    pc       = '0;
    rs1_data = '0;
    rs2_data = '0;
    load_table();

    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    @(negedge clk);
    check_value("result_valid after reset", result_valid, 0);
    check_value("result after reset", result, 0);
    check_value("rd after reset", rd, 0);
    check_value("illegal after reset", illegal, 0);

    fork
      drive_rows();
      watch_results();
    join

    check_idle();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* flist.f */
+incdir+tests
source/rv_isa_pkg.sv
source/alu_pkg.sv
source/instr_decoder.sv
source/alu_core.sv
source/result_formatter.sv
source/exec_unit.sv
tests/exec_unit_tb.sv
